// ==== compile.f ====
design/coef_pkg.sv
design/axil_write_channel.sv
design/axil_read_channel.sv
design/coef_reg_file.sv
design/dot_product_pipe.sv
design/coef_dot_product_top.sv
bench/tb_coef_dot_product.sv

// ==== Makefile ====
# Verilator build and run for the coefficient block testbench.
# Every variable can be overridden on the command line.

VERILATOR   ?= verilator
TOP         ?= tb_coef_dot_product
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= TEST PASS
VFLAGS      ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_STRING)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_coef_dot_product.sv ====
// Testbench for the coefficient block: AXI4-Lite tasks, shadow coefficient
// model, reference inner product, product checker and directed tests.

`timescale 1ns/1ps
`default_nettype none

module tb_coef_dot_product;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int WORD_LSB = $clog2(DATA_W / 8);
    localparam int TIMEOUT  = 100;

    typedef logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0] vec_t;

    // Expected product and the edge count at which it must be visible.
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic [31:0]       due;
    } prod_exp_t;

    logic                   i_clk = 1'b0;
    logic                   i_sync_rst;
    coef_pkg::axil_wr_req_t wr_req;
    coef_pkg::axil_wr_rsp_t wr_rsp;
    coef_pkg::axil_rd_req_t rd_req;
    coef_pkg::axil_rd_rsp_t rd_rsp;
    vec_t                   vec;
    logic                   vec_valid;
    logic [DATA_W-1:0]      prod;
    logic                   prod_valid;

    // Shadow copy of the coefficient registers.
    vec_t        shadow;
    prod_exp_t   exp_q[$];
    int          seed        = 87;
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] edge_count  = '0;

    always #4 i_clk = ~i_clk;

    // Rising edges seen so far, read only at falling edges.
    always @(posedge i_clk) edge_count <= edge_count + 1;

    coef_dot_product_top #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) dut (
        .i_clk         (i_clk),
        .i_sync_rst    (i_sync_rst),
        .i_axil_wr_req (wr_req),
        .o_axil_wr_rsp (wr_rsp),
        .i_axil_rd_req (rd_req),
        .o_axil_rd_rsp (rd_rsp),
        .i_vec         (vec),
        .i_vec_valid   (vec_valid),
        .o_prod        (prod),
        .o_prod_valid  (prod_valid)
    );

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // Upper address bits must be zero and the word index below COEF_COUNT.
    function automatic logic word_in_range(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] upper;
        upper = addr >> (WORD_LSB + coef_pkg::COEF_IDX_W);
        return (upper == '0) && (int'(word_idx(addr)) < coef_pkg::COEF_COUNT);
    endfunction

    function automatic logic [coef_pkg::COEF_IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
        return addr[WORD_LSB +: coef_pkg::COEF_IDX_W];
    endfunction

    // Byte lanes with a set strobe take the new data.
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
            input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    // Full-width products, each cut to DATA_W, summed modulo 2**DATA_W.
    function automatic logic [DATA_W-1:0] ref_dot(input vec_t v, input vec_t c);
        logic [2*DATA_W-1:0] full;
        logic [DATA_W-1:0]   acc;
        acc = '0;
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) begin
            full = {{DATA_W{1'b0}}, v[i]} * {{DATA_W{1'b0}}, c[i]};
            acc  = acc + full[DATA_W-1:0];
        end
        return acc;
    endfunction

    // ----------------------------------------------------------
    // Checking and end of run
    // ----------------------------------------------------------

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        error_count++;
        $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        finish_run();
    endtask

    // ----------------------------------------------------------
    // AXI4-Lite master tasks
    // ----------------------------------------------------------

    task automatic drive_write_request(input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        @(posedge i_clk);
        wr_req.awvalid <= 1'b1;
        wr_req.awaddr  <= addr;
        wr_req.wvalid  <= 1'b1;
        wr_req.wdata   <= 64'(data);
        wr_req.wstrb   <= 8'(strb);
    endtask

    // Hold both valids until the edge where the readies are seen.
    task automatic wait_write_accept();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (wr_rsp.awready !== 1'b1) begin
            if (cycles >= TIMEOUT) timeout_fail("awready");
            cycles++;
            @(negedge i_clk);
        end
        check_value("wready with awready", 64'(1'b1), 64'(wr_rsp.wready));
        @(posedge i_clk);
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
    endtask

    // bready stays low for hold cycles; B must hold and AW/W stay closed.
    task automatic collect_write_response(input int hold, output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (wr_rsp.bvalid !== 1'b1) begin
            if (cycles >= TIMEOUT) timeout_fail("bvalid");
            cycles++;
            @(negedge i_clk);
        end
        resp = wr_rsp.bresp;
        repeat (hold) begin
            @(negedge i_clk);
            check_value("bvalid hold", 64'(1'b1), 64'(wr_rsp.bvalid));
            check_value("awready while B pending", 64'(1'b0), 64'(wr_rsp.awready));
        end
        @(posedge i_clk);
        wr_req.bready <= 1'b1;
        @(posedge i_clk);
        wr_req.bready <= 1'b0;
    endtask

    // Checks bresp and applies an in-range write to the shadow copy.
    task automatic record_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
            input logic [STRB_W-1:0] strb, input logic [1:0] resp, input string name);
        logic [1:0] exp_resp;
        exp_resp = word_in_range(addr) ? coef_pkg::RESP_OKAY : coef_pkg::RESP_SLVERR;
        check_value($sformatf("%s bresp", name), 64'(exp_resp), 64'(resp));
        if (word_in_range(addr)) begin
            shadow[word_idx(addr)] = merge_bytes(shadow[word_idx(addr)], data, strb);
        end
    endtask

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
            input logic [STRB_W-1:0] strb, input string name);
        logic [1:0] resp;
        drive_write_request(addr, data, strb);
        wait_write_accept();
        collect_write_response(0, resp);
        record_write(addr, data, strb, resp, name);
    endtask

    // Read and compare with the shadow copy, rready low for hold cycles.
    task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold, input string name);
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        int                cycles;
        @(posedge i_clk);
        rd_req.arvalid <= 1'b1;
        rd_req.araddr  <= addr;
        cycles = 0;
        @(negedge i_clk);
        while (rd_rsp.arready !== 1'b1) begin
            if (cycles >= TIMEOUT) timeout_fail("arready");
            cycles++;
            @(negedge i_clk);
        end
        @(posedge i_clk);
        rd_req.arvalid <= 1'b0;
        cycles = 0;
        @(negedge i_clk);
        while (rd_rsp.rvalid !== 1'b1) begin
            if (cycles >= TIMEOUT) timeout_fail("rvalid");
            cycles++;
            @(negedge i_clk);
        end
        data = rd_rsp.rdata[DATA_W-1:0];
        resp = rd_rsp.rresp;
        repeat (hold) begin
            @(negedge i_clk);
            check_value($sformatf("%s rvalid hold", name), 64'(1'b1), 64'(rd_rsp.rvalid));
            check_value($sformatf("%s rdata hold", name), 64'(data),
                        64'(rd_rsp.rdata[DATA_W-1:0]));
        end
        @(posedge i_clk);
        rd_req.rready <= 1'b1;
        @(posedge i_clk);
        rd_req.rready <= 1'b0;
        if (word_in_range(addr)) begin
            check_value($sformatf("%s rdata", name), 64'(shadow[word_idx(addr)]), 64'(data));
            check_value($sformatf("%s rresp", name), 64'(coef_pkg::RESP_OKAY), 64'(resp));
        end else begin
            check_value($sformatf("%s rdata", name), 64'(0), 64'(data));
            check_value($sformatf("%s rresp", name), 64'(coef_pkg::RESP_SLVERR), 64'(resp));
        end
    endtask

    // ----------------------------------------------------------
    // Vector stream
    // ----------------------------------------------------------

    task automatic send_vectors(input int count, input bit with_gaps);
        for (int n = 0; n < count; n++) begin
            @(posedge i_clk);
            vec_valid <= !with_gaps || (n % 2 == 0);
            for (int k = 0; k < coef_pkg::COEF_COUNT; k++) begin
                vec[k] <= $random(seed);
            end
        end
        @(posedge i_clk);
        vec_valid <= 1'b0;
    endtask

    task automatic wait_products();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (exp_q.size() != 0) begin
            if (cycles >= TIMEOUT) timeout_fail("expected products");
            cycles++;
            @(negedge i_clk);
        end
    endtask

    // Compare first, then queue the vector that the next edge samples.
    // Its product must be visible two falling edges later.
    always @(negedge i_clk) begin
        prod_exp_t head;
        if (i_sync_rst !== 1'b1) begin
            if (prod_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Product %h appeared with no vector in flight", prod);
                end else begin
                    head = exp_q.pop_front();
                    check_value("product value", 64'(head.value), 64'(prod));
                    check_value("product latency", 64'(head.due), 64'(edge_count));
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= edge_count) begin
                error_count++;
                $display("Product due at edge %0d never appeared", exp_q[0].due);
                exp_q.delete(0);
            end
            if (vec_valid === 1'b1) begin
                head.value = ref_dot(vec, shadow);
                head.due   = edge_count + 2;
                exp_q.push_back(head);
            end
        end
    end

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    initial begin
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] word2;
        logic [STRB_W-1:0] strb;
        logic [1:0]        resp;
        i_sync_rst = 1'b1;
        wr_req     = '0;
        rd_req     = '0;
        vec        = '0;
        vec_valid  = 1'b0;
        shadow     = '0;
        repeat (4) @(posedge i_clk);
        i_sync_rst <= 1'b0;

        // Reset values, and no product without a vector.
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) axil_read(i * 4, 0, "reset read");
        repeat (6) begin
            @(negedge i_clk);
            check_value("idle prod_valid", 64'(1'b0), 64'(prod_valid));
        end

        // Full-strobe writes and readback.
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) begin
            word = $random(seed);
            axil_write(i * 4, word, '1, "full write");
        end
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) axil_read(i * 4, 0, "full readback");

        // Partial strobes touch only their byte lanes.
        for (int n = 0; n < 12; n++) begin
            word = $random(seed);
            strb = STRB_W'($random(seed));
            axil_write((n % 4) * 4, word, strb, "partial write");
            axil_read((n % 4) * 4, 0, "partial readback");
        end

        // Out-of-range words answer SLVERR and leave the registers alone.
        axil_write(32'h0000_0010, $random(seed), '1, "range write word 4");
        axil_write(32'h0000_0104, $random(seed), '1, "range write far");
        axil_write(32'h8000_0000, $random(seed), '1, "range write upper bits");
        axil_read(32'h0000_0010, 0, "range read word 4");
        axil_read(32'h4000_000C, 0, "range read upper bits");
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) axil_read(i * 4, 0, "range readback");

        // Back-to-back vectors.
        send_vectors(24, 1'b0);
        wait_products();

        // Second write waits while B is held off.
        word  = $random(seed);
        word2 = $random(seed);
        drive_write_request(32'h4, word, '1);
        wait_write_accept();
        drive_write_request(32'h8, word2, '1);
        collect_write_response(6, resp);
        record_write(32'h4, word, '1, resp, "held write");
        wait_write_accept();
        collect_write_response(0, resp);
        record_write(32'h8, word2, '1, resp, "queued write");
        axil_read(32'h4, 5, "held read");
        axil_read(32'h8, 5, "queued read");

        // New coefficients, vectors with gaps.
        send_vectors(10, 1'b1);
        wait_products();

        finish_run();
    end

endmodule

`default_nettype wire

// ==== design/coef_dot_product_top.sv ====
// Top level: AXI4-Lite write and read channels, coefficient registers,
// and the inner product pipeline.

`timescale 1ns/1ps
`default_nettype none

module coef_dot_product_top #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  wire logic                                          i_clk,
    input  wire logic                                          i_sync_rst,
    // AXI4-Lite slave port.
    input  wire coef_pkg::axil_wr_req_t                        i_axil_wr_req,
    output var  coef_pkg::axil_wr_rsp_t                        o_axil_wr_rsp,
    input  wire coef_pkg::axil_rd_req_t                        i_axil_rd_req,
    output var  coef_pkg::axil_rd_rsp_t                        o_axil_rd_rsp,
    // Vector stream, no back-pressure.
    input  wire logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0]   i_vec,
    input  wire logic                                          i_vec_valid,
    output var  logic [DATA_W-1:0]                             o_prod,
    output var  logic                                          o_prod_valid
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------

    coef_pkg::coef_wr_t                          coef_wr;
    logic [coef_pkg::COEF_IDX_W-1:0]             rd_idx;
    logic [DATA_W-1:0]                           rd_data;
    logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0] coefs;

    // Write decode and B response.
    axil_write_channel #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_wr_ch (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_req      (i_axil_wr_req),
        .o_rsp      (o_axil_wr_rsp),
        .o_coef_wr  (coef_wr)
    );

    // Read decode and R response.
    axil_read_channel #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_rd_ch (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_req      (i_axil_rd_req),
        .o_rsp      (o_axil_rd_rsp),
        .o_rd_idx   (rd_idx),
        .i_rd_data  (rd_data)
    );

    // Coefficient storage.
    coef_reg_file #(
        .DATA_W (DATA_W)
    ) u_regs (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_coef_wr  (coef_wr),
        .i_rd_idx   (rd_idx),
        .o_rd_data  (rd_data),
        .o_coefs    (coefs)
    );

    // Inner product, two cycles of latency.
    dot_product_pipe #(
        .DATA_W (DATA_W)
    ) u_pipe (
        .i_clk        (i_clk),
        .i_sync_rst   (i_sync_rst),
        .i_vec        (i_vec),
        .i_vec_valid  (i_vec_valid),
        .i_coefs      (coefs),
        .o_prod       (o_prod),
        .o_prod_valid (o_prod_valid)
    );

endmodule

`default_nettype wire

// ==== design/dot_product_pipe.sv ====
// Two-stage inner product pipeline.
// Stage one multiplies, stage two sums, both truncated to DATA_W.

`timescale 1ns/1ps
`default_nettype none

module dot_product_pipe #(
    parameter int DATA_W = 32
) (
    input  wire logic                                          i_clk,
    input  wire logic                                          i_sync_rst,
    input  wire logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0]   i_vec,
    input  wire logic                                          i_vec_valid,
    input  wire logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0]   i_coefs,
    output var  logic [DATA_W-1:0]                             o_prod,
    output var  logic                                          o_prod_valid
);

    // Valid bit per stage, one vector each.
    logic [1:0]                                  r_valid_sr;
    // Stage one products.
    logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0] r_prod;
    logic [DATA_W-1:0]                           prod_sum;

    // ----------------------------------------------------------
    // Valid tracking
    // ----------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_valid_sr <= '0;
        end else begin
            r_valid_sr <= {r_valid_sr[0], i_vec_valid};
        end
    end

    assign o_prod_valid = r_valid_sr[1];

    // ----------------------------------------------------------
    // Stage one
    // ----------------------------------------------------------

    // Coefficients are sampled on the same edge as the vector.
    always_ff @(posedge i_clk) begin
        if (i_vec_valid) begin
            for (int i = 0; i < coef_pkg::COEF_COUNT; i++) begin
                r_prod[i] <= i_vec[i] * i_coefs[i];
            end
        end
    end

    // ----------------------------------------------------------
    // Stage two
    // ----------------------------------------------------------

    // Adder tree, wraps at DATA_W.
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < coef_pkg::COEF_COUNT; i++) begin
            prod_sum = prod_sum + r_prod[i];
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_valid_sr[0]) begin
            o_prod <= prod_sum;
        end
    end

    // Fixed two-cycle latency, in both directions.
    a_latency: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_vec_valid |-> ##2 o_prod_valid);
    a_no_spurious: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        !i_vec_valid |-> ##2 !o_prod_valid);

endmodule

`default_nettype wire

// ==== design/coef_reg_file.sv ====
// Four byte-strobed coefficient registers.
// Read mux and full coefficient vector.

`timescale 1ns/1ps
`default_nettype none

module coef_reg_file #(
    parameter int DATA_W = 32
) (
    input  wire logic                                          i_clk,
    input  wire logic                                          i_sync_rst,
    input  wire coef_pkg::coef_wr_t                            i_coef_wr,
    input  wire logic [coef_pkg::COEF_IDX_W-1:0]               i_rd_idx,
    output var  logic [DATA_W-1:0]                             o_rd_data,
    output var  logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0]   o_coefs
);

    localparam int STRB_W = DATA_W / 8;

    logic [coef_pkg::COEF_COUNT-1:0][DATA_W-1:0] r_coefs;

    // ----------------------------------------------------------
    // Strobed write
    // ----------------------------------------------------------

    // The write channel only issues in-range indices.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_coefs <= '0;
        end else if (i_coef_wr.en) begin
            for (int b = 0; b < STRB_W; b++) begin
                // Update only the enabled bytes.
                if (i_coef_wr.strb[b]) begin
                    r_coefs[i_coef_wr.idx][b*8 +: 8] <= i_coef_wr.data[b*8 +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Read side
    // ----------------------------------------------------------

    // Combinational read for the read channel.
    assign o_rd_data = r_coefs[i_rd_idx];

    // Whole vector for the pipeline.
    assign o_coefs = r_coefs;

endmodule

`default_nettype wire

// ==== design/axil_read_channel.sv ====
// AXI4-Lite read channel: AR capture, range decode, R data and response.

`timescale 1ns/1ps
`default_nettype none

module axil_read_channel #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_sync_rst,
    input  wire coef_pkg::axil_rd_req_t            i_req,
    output var  coef_pkg::axil_rd_rsp_t            o_rsp,
    output var  logic [coef_pkg::COEF_IDX_W-1:0]   o_rd_idx,
    input  wire logic [DATA_W-1:0]                 i_rd_data
);

    // Byte offset bits inside one data word.
    localparam int ADDR_LSB = $clog2(DATA_W / 8);

    coef_pkg::rd_state_e  r_state;
    logic                 r_arready;
    logic                 r_rvalid;
    logic [ADDR_W-1:0]    r_araddr;
    logic [DATA_W-1:0]    r_rdata;
    coef_pkg::axil_resp_e r_rresp;

    logic                 rd_hs;
    logic [ADDR_W-1:0]    rd_word;
    logic                 rd_in_range;

    assign rd_hs = r_arready && i_req.arvalid;

    // Word index and range of the latched address.
    assign rd_word     = r_araddr >> ADDR_LSB;
    assign rd_in_range = (rd_word < ADDR_W'(coef_pkg::COEF_COUNT));
    // Index into the register file, data comes back in the same cycle.
    assign o_rd_idx    = rd_word[coef_pkg::COEF_IDX_W-1:0];

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_state   <= coef_pkg::RD_IDLE;
            r_arready <= 1'b0;
            r_rvalid  <= 1'b0;
        end else begin
            case (r_state)
                coef_pkg::RD_IDLE: begin
                    if (i_req.arvalid) begin
                        r_state   <= coef_pkg::RD_ACCEPT;
                        r_arready <= 1'b1;
                    end
                end
                coef_pkg::RD_ACCEPT: begin
                    // Data is valid right after the address handshake.
                    if (rd_hs) begin
                        r_state   <= coef_pkg::RD_DATA;
                        r_arready <= 1'b0;
                        r_rvalid  <= 1'b1;
                    end
                end
                coef_pkg::RD_DATA: begin
                    if (i_req.rready) begin
                        r_state  <= coef_pkg::RD_IDLE;
                        r_rvalid <= 1'b0;
                    end
                end
                default: begin
                    r_state <= coef_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Address capture, then data and response on the handshake edge.
    always_ff @(posedge i_clk) begin
        if (r_state == coef_pkg::RD_IDLE && i_req.arvalid) begin
            r_araddr <= i_req.araddr[ADDR_W-1:0];
        end
        if (rd_hs) begin
            // Out-of-range reads return zero.
            r_rdata <= rd_in_range ? i_rd_data : '0;
            r_rresp <= rd_in_range ? coef_pkg::RESP_OKAY : coef_pkg::RESP_SLVERR;
        end
    end

    always_comb begin
        o_rsp                    = '0;
        o_rsp.arready            = r_arready;
        o_rsp.rvalid             = r_rvalid;
        o_rsp.rdata[DATA_W-1:0]  = r_rdata;
        o_rsp.rresp              = r_rresp;
    end

    // Read data holds under back-pressure.
    a_rdata_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        r_rvalid && !i_req.rready |=> r_rvalid && $stable(r_rdata));

endmodule

`default_nettype wire

// ==== design/axil_write_channel.sv ====
// AXI4-Lite write channel: AW/W capture, range decode, write command, B response.

`timescale 1ns/1ps
`default_nettype none

module axil_write_channel #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  wire logic                   i_clk,
    input  wire logic                   i_sync_rst,
    input  wire coef_pkg::axil_wr_req_t i_req,
    output var  coef_pkg::axil_wr_rsp_t o_rsp,
    output var  coef_pkg::coef_wr_t     o_coef_wr
);

    // Byte offset bits inside one data word.
    localparam int ADDR_LSB = $clog2(DATA_W / 8);
    localparam int STRB_W   = DATA_W / 8;

    coef_pkg::wr_state_e  r_state;
    logic                 r_awready;
    logic                 r_wready;
    logic                 r_bvalid;
    coef_pkg::axil_resp_e r_bresp;

    // Latched transaction payload.
    logic [ADDR_W-1:0]    r_awaddr;
    logic [DATA_W-1:0]    r_wdata;
    logic [STRB_W-1:0]    r_wstrb;

    logic                 wr_hs;
    logic [ADDR_W-1:0]    wr_word;
    logic                 wr_in_range;

    // Both channels complete together on the same edge.
    assign wr_hs = r_awready && i_req.awvalid && r_wready && i_req.wvalid;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------

    // Word index of the latched address.
    assign wr_word = r_awaddr >> ADDR_LSB;
    // Anything past the last coefficient word is an error.
    assign wr_in_range = (wr_word < ADDR_W'(coef_pkg::COEF_COUNT));

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_state   <= coef_pkg::WR_IDLE;
            r_awready <= 1'b0;
            r_wready  <= 1'b0;
            r_bvalid  <= 1'b0;
        end else begin
            case (r_state)
                coef_pkg::WR_IDLE: begin
                    // Wait for address and data together.
                    if (i_req.awvalid && i_req.wvalid) begin
                        r_state   <= coef_pkg::WR_ACCEPT;
                        r_awready <= 1'b1;
                        r_wready  <= 1'b1;
                    end
                end
                coef_pkg::WR_ACCEPT: begin
                    // Readies drop after the handshake edge.
                    if (wr_hs) begin
                        r_state   <= coef_pkg::WR_RESP;
                        r_awready <= 1'b0;
                        r_wready  <= 1'b0;
                        r_bvalid  <= 1'b1;
                    end
                end
                coef_pkg::WR_RESP: begin
                    // Hold the response until the master takes it.
                    if (i_req.bready) begin
                        r_state  <= coef_pkg::WR_IDLE;
                        r_bvalid <= 1'b0;
                    end
                end
                default: begin
                    r_state <= coef_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // Payload capture and response code.
    always_ff @(posedge i_clk) begin
        if (r_state == coef_pkg::WR_IDLE && i_req.awvalid && i_req.wvalid) begin
            r_awaddr <= i_req.awaddr[ADDR_W-1:0];
            r_wdata  <= i_req.wdata[DATA_W-1:0];
            r_wstrb  <= i_req.wstrb[STRB_W-1:0];
        end
        if (wr_hs) begin
            r_bresp <= wr_in_range ? coef_pkg::RESP_OKAY : coef_pkg::RESP_SLVERR;
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    always_comb begin
        o_rsp         = '0;
        o_rsp.awready = r_awready;
        o_rsp.wready  = r_wready;
        o_rsp.bvalid  = r_bvalid;
        o_rsp.bresp   = r_bresp;
    end

    // One-cycle write command, only for in-range words.
    always_comb begin
        o_coef_wr                   = '0;
        o_coef_wr.en                = wr_hs && wr_in_range;
        o_coef_wr.idx               = wr_word[coef_pkg::COEF_IDX_W-1:0];
        o_coef_wr.data[DATA_W-1:0]  = r_wdata;
        o_coef_wr.strb[STRB_W-1:0]  = r_wstrb;
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------

    // AW and W are accepted as one transfer in exactly one cycle.
    a_ready_pair: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        r_awready |=> !r_awready && !r_wready);

    // Response holds until the master is ready.
    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        r_bvalid && !i_req.bready |=> r_bvalid);

endmodule

`default_nettype wire

// ==== design/coef_pkg.sv ====
// Shared widths, AXI4-Lite response codes and channel state encodings.
// Packed request and response structs for the write and read channels.
// Register file write command.

`default_nettype none

package coef_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------

    // Number of coefficient registers.
    localparam int COEF_COUNT = 4;
    // Width of a coefficient index.
    localparam int COEF_IDX_W = 2;
    // Upper bounds for the struct fields.
    // Modules use only the low ADDR_W and DATA_W bits.
    localparam int MAX_ADDR_W = 32;
    localparam int MAX_DATA_W = 64;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------

    // AXI4-Lite response codes used by this slave.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Write channel FSM.
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_e;

    // Read channel FSM.
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_DATA
    } rd_state_e;

    // ----------------------------------------------------------
    // Channel structs
    // ----------------------------------------------------------

    // Write side, driven by the master.
    typedef struct packed {
        logic                    awvalid;
        logic [MAX_ADDR_W-1:0]   awaddr;
        logic                    wvalid;
        logic [MAX_DATA_W-1:0]   wdata;
        logic [MAX_DATA_W/8-1:0] wstrb;
        logic                    bready;
    } axil_wr_req_t;

    // Write side, driven by the slave.
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
    } axil_wr_rsp_t;

    // Read side, driven by the master.
    typedef struct packed {
        logic                  arvalid;
        logic [MAX_ADDR_W-1:0] araddr;
        logic                  rready;
    } axil_rd_req_t;

    // Read side, driven by the slave.
    typedef struct packed {
        logic                  arready;
        logic                  rvalid;
        logic [MAX_DATA_W-1:0] rdata;
        axil_resp_e            rresp;
    } axil_rd_rsp_t;

    // Write command from the write channel to the register file.
    typedef struct packed {
        logic                    en;
        logic [COEF_IDX_W-1:0]   idx;
        logic [MAX_DATA_W-1:0]   data;
        logic [MAX_DATA_W/8-1:0] strb;
    } coef_wr_t;

endpackage

`default_nettype wire
